// File: sources.f
+incdir+sim
design/smartnic_pkg.sv
design/igr_tdest_demux.sv
design/app_full_pipe.sv
design/egr_pkt_mux.sv
design/app_reg_blk.sv
design/smartnic_app.sv
sim/tb_smartnic_app.sv

// File: Makefile
# Verilator run of the smartnic_app testbench

VERILATOR ?= verilator
TOP       ?= tb_smartnic_app
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and scan $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "Result: passed" || \
		(echo "Result: failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/smartnic_app_stimulus.txt
# I ingress / H h2c: dest beats first_word    R read: addr expected    W write: addr data
# D waits until all traffic has drained, every number is hex
R 00 0
R 04 0
R 08 0
R 0C 0
I 2 4 1000
I 0 3 2000
H 0 4 3000
I 3 1 1100
I 1 5 2100
H 1 2 3100
I 0 2 2200
H 2 6 3200
I 2 7 1200
D
R 00 6
R 04 3
R 08 6
R 0C 3
W 10 1
R 00 0
R 04 0
R 08 0
R 0C 0
R 14 0

// File: sim/tb_stream_tasks.svh
`ifndef TB_STREAM_TASKS_SVH
`define TB_STREAM_TASKS_SVH

// ----------------------------------------------------------------------
// Scoreboard state
// ----------------------------------------------------------------------
// Expected beats packed as {dest, last, data}
logic [66:0] c2h_exp [$];
logic [66:0] app_exp [$];
logic [66:0] h2c_exp [$];

int errors       = 0;
int pkts_checked = 0;
int igr_done     = 0;
int c2h_done     = 0;
int egr_done     = 0;
int h2c_done     = 0;
int seed         = 32'ha5e5_946e;

// Egress packet in progress and the queue it came from
logic egr_mid      = 1'b0;
logic egr_from_h2c = 1'b0;

task automatic check(input string name, input logic [63:0] expected,
                     input logic [63:0] actual);
    if (actual !== expected) begin
        errors++;
        $display("ERR t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
    end
endtask

task automatic take_c2h();
    logic [66:0] exp_beat;
    if (c2h_exp.size() == 0) begin
        errors++;
        $display("Unexpected beat on c2h at %0t with data %0h", $time, c2h_data);
    end else begin
        exp_beat = c2h_exp.pop_front();
        check("c2h_data", exp_beat[63:0], c2h_data);
        check("c2h_last", 64'(exp_beat[64]), 64'(c2h_last));
        check("c2h_dest", 64'(exp_beat[66:65]), 64'(c2h_dest));
    end
    if (c2h_last) begin
        c2h_done++;
        pkts_checked++;
    end
endtask

task automatic take_egr();
    logic [66:0] got;
    logic [66:0] exp_beat;
    got = {egr_dest, egr_last, egr_data};
    // First beat of a packet picks the source queue
    if (!egr_mid) begin
        if (app_exp.size() > 0 && app_exp[0] === got) begin
            egr_from_h2c = 1'b0;
            egr_mid      = 1'b1;
        end else if (h2c_exp.size() > 0 && h2c_exp[0] === got) begin
            egr_from_h2c = 1'b1;
            egr_mid      = 1'b1;
        end else begin
            errors++;
            $display("Egress beat at %0t with data %0h starts no expected packet",
                     $time, egr_data);
        end
    end
    if (egr_mid) begin
        if (egr_from_h2c && h2c_exp.size() > 0) begin
            exp_beat = h2c_exp.pop_front();
        end else if (!egr_from_h2c && app_exp.size() > 0) begin
            exp_beat = app_exp.pop_front();
        end else begin
            exp_beat = '1;
            errors++;
            $display("Egress packet at %0t runs past its expected length", $time);
        end
        check("egr_data", exp_beat[63:0], egr_data);
        check("egr_last", 64'(exp_beat[64]), 64'(egr_last));
        check("egr_dest", 64'(exp_beat[66:65]), 64'(egr_dest));
        egr_mid = !egr_last;
    end
    if (egr_last) begin
        egr_done++;
        pkts_checked++;
    end
endtask

// Random back-pressure on the two outputs, sampled just before the rising edge
initial begin : stream_monitor
    c2h_ready = 1'b0;
    egr_ready = 1'b0;
    wait (rst_n === 1'b1);
    forever begin
        @(negedge core_clk);
        c2h_ready = ($random(seed) & 3) != 0;
        egr_ready = ($random(seed) & 3) != 0;
        #3;
        if (c2h_valid && c2h_ready) begin
            take_c2h();
        end
        if (egr_valid && egr_ready) begin
            take_egr();
        end
    end
end

// ----------------------------------------------------------------------
// Wishbone classic access
// ----------------------------------------------------------------------
task automatic wb_access(input logic we, input wb_addr_t adr, input wb_data_t wdata,
                         output wb_data_t rdata);
    int waited;
    waited = 0;
    rdata  = '0;
    @(negedge core_clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_wdata = wdata;
    #3;
    while (!wb_ack && waited < 16) begin
        @(negedge core_clk);
        #3;
        waited++;
    end
    if (wb_ack) begin
        rdata = wb_rdata;
    end else begin
        errors++;
        $display("No wb_ack within 16 cycles for address %0h at %0t", adr, $time);
    end
    @(negedge core_clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
endtask

`endif

// File: sim/tb_smartnic_app.sv
`timescale 1ns/1ps

module tb_smartnic_app;
    import smartnic_pkg::*;

    localparam int    DATA_WIDTH = 64;
    localparam int    MAX_OPS    = 64;
    localparam string STIM_FILE  = "sim/smartnic_app_stimulus.txt";

    logic                  core_clk;
    logic                  rst_n;
    logic                  igr_valid;
    logic                  igr_ready;
    logic [DATA_WIDTH-1:0] igr_data;
    logic                  igr_last;
    port_t                 igr_dest;
    logic                  c2h_valid;
    logic                  c2h_ready;
    logic [DATA_WIDTH-1:0] c2h_data;
    logic                  c2h_last;
    port_t                 c2h_dest;
    logic                  h2c_valid;
    logic                  h2c_ready;
    logic [DATA_WIDTH-1:0] h2c_data;
    logic                  h2c_last;
    port_t                 h2c_dest;
    logic                  egr_valid;
    logic                  egr_ready;
    logic [DATA_WIDTH-1:0] egr_data;
    logic                  egr_last;
    port_t                 egr_dest;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    wb_addr_t              wb_adr;
    wb_data_t              wb_wdata;
    logic                  wb_ack;
    wb_data_t              wb_rdata;

    // Stimulus lines, a kind letter and up to three hex fields
    logic [7:0]  op_kind [MAX_OPS];
    logic [63:0] op_a    [MAX_OPS];
    logic [63:0] op_b    [MAX_OPS];
    logic [63:0] op_c    [MAX_OPS];
    int          n_ops       = 0;
    int          total_beats = 0;

    // Packets waiting for the ingress and h2c drivers
    int   igr_pend [$];
    int   h2c_pend [$];
    logic igr_busy;
    logic h2c_busy;

    `include "tb_stream_tasks.svh"

    smartnic_app #(.DATA_WIDTH(DATA_WIDTH)) UUT (.*);

    initial begin : clock_gen
        core_clk = 1'b0;
        forever #4 core_clk = ~core_clk;
    end

    task automatic load_stimulus();
        int          fd;
        int          cnt;
        string       line;
        logic [7:0]  kind;
        logic [63:0] f1;
        logic [63:0] f2;
        logic [63:0] f3;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open the stimulus file %s", STIM_FILE);
            return;
        end
        while (!$feof(fd) && n_ops < MAX_OPS) begin
            cnt = $fgets(line, fd);
            if (cnt > 0 && line[0] != "#" && line[0] != "\n") begin
                f1  = '0;
                f2  = '0;
                f3  = '0;
                cnt = $sscanf(line, "%c %h %h %h", kind, f1, f2, f3);
                op_kind[n_ops] = kind;
                op_a[n_ops]    = f1;
                op_b[n_ops]    = f2;
                op_c[n_ops]    = f3;
                if (kind == "I" || kind == "H") begin
                    total_beats += int'(f2);
                end
                n_ops++;
            end
        end
        $fclose(fd);
    endtask

    // Host codes leave on c2h, everything else takes the application path
    task automatic queue_packet(input int idx, input logic from_h2c);
        logic [66:0] beat;
        logic        to_host;
        int          n;
        n       = int'(op_b[idx]);
        to_host = (op_a[idx][1:0] == PORT_HOST0) || (op_a[idx][1:0] == PORT_HOST1);
        for (int k = 0; k < n; k++) begin
            beat = {op_a[idx][1:0], (k == n - 1), op_c[idx] + 64'(k)};
            if (from_h2c) begin
                h2c_exp.push_back(beat);
            end else if (to_host) begin
                c2h_exp.push_back(beat);
            end else begin
                app_exp.push_back(beat);
            end
        end
        if (from_h2c) begin
            h2c_pend.push_back(idx);
        end else begin
            igr_pend.push_back(idx);
        end
    endtask

    // ----------------------------------------------------------------------
    // Stream drivers
    // ----------------------------------------------------------------------
    task automatic drive_ingress(input int idx);
        for (int k = 0; k < int'(op_b[idx]); k++) begin
            @(negedge core_clk);
            igr_valid = 1'b1;
            igr_data  = op_c[idx] + 64'(k);
            igr_last  = (k == int'(op_b[idx]) - 1);
            igr_dest  = op_a[idx][1:0];
            #3;
            while (!igr_ready) begin
                @(negedge core_clk);
                #3;
            end
        end
        igr_done++;
        @(negedge core_clk);
        igr_valid = 1'b0;
        igr_last  = 1'b0;
    endtask

    task automatic drive_h2c(input int idx);
        for (int k = 0; k < int'(op_b[idx]); k++) begin
            @(negedge core_clk);
            h2c_valid = 1'b1;
            h2c_data  = op_c[idx] + 64'(k);
            h2c_last  = (k == int'(op_b[idx]) - 1);
            h2c_dest  = op_a[idx][1:0];
            #3;
            while (!h2c_ready) begin
                @(negedge core_clk);
                #3;
            end
        end
        h2c_done++;
        @(negedge core_clk);
        h2c_valid = 1'b0;
        h2c_last  = 1'b0;
    endtask

    initial begin : ingress_driver
        int idx;
        igr_valid = 1'b0;
        igr_data  = '0;
        igr_last  = 1'b0;
        igr_dest  = PORT_P0;
        igr_busy  = 1'b0;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge core_clk);
            if (igr_pend.size() > 0) begin
                igr_busy = 1'b1;
                idx      = igr_pend.pop_front();
                drive_ingress(idx);
                igr_busy = 1'b0;
            end
        end
    end

    initial begin : h2c_driver
        int idx;
        h2c_valid = 1'b0;
        h2c_data  = '0;
        h2c_last  = 1'b0;
        h2c_dest  = PORT_P0;
        h2c_busy  = 1'b0;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge core_clk);
            if (h2c_pend.size() > 0) begin
                h2c_busy = 1'b1;
                idx      = h2c_pend.pop_front();
                drive_h2c(idx);
                h2c_busy = 1'b0;
            end
        end
    end

    task automatic drain();
        @(negedge core_clk);
        while (igr_pend.size() > 0 || h2c_pend.size() > 0 || igr_busy || h2c_busy ||
               c2h_exp.size() > 0 || app_exp.size() > 0 || h2c_exp.size() > 0) begin
            @(negedge core_clk);
        end
        // Counters take the last transfer on the edge after it is seen
        repeat (2) @(negedge core_clk);
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin : main_flow
        wb_data_t rdata;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_wdata = '0;
        load_stimulus();
        repeat (16) @(posedge core_clk);
        @(negedge core_clk);
        rst_n = 1'b1;
        #1;
        check("egr_valid", 64'd0, 64'(egr_valid));
        check("wb_ack", 64'd0, 64'(wb_ack));
        for (int i = 0; i < n_ops; i++) begin
            case (op_kind[i])
                "I": queue_packet(i, 1'b0);
                "H": queue_packet(i, 1'b1);
                "D": drain();
                "R": begin
                    wb_access(1'b0, op_a[i][7:0], '0, rdata);
                    check("wb_rdata", op_b[i], 64'(rdata));
                    // Counter reads also match the packets seen here
                    case (op_a[i][7:0])
                        REG_IGR_PKTS: check("wb_rdata igr_pkts", 64'(igr_done), 64'(rdata));
                        REG_C2H_PKTS: check("wb_rdata c2h_pkts", 64'(c2h_done), 64'(rdata));
                        REG_EGR_PKTS: check("wb_rdata egr_pkts", 64'(egr_done), 64'(rdata));
                        REG_H2C_PKTS: check("wb_rdata h2c_pkts", 64'(h2c_done), 64'(rdata));
                        default: ;
                    endcase
                end
                "W": begin
                    wb_access(1'b1, op_a[i][7:0], op_b[i][31:0], rdata);
                    if (op_a[i][7:0] == REG_CLEAR) begin
                        igr_done = 0;
                        c2h_done = 0;
                        egr_done = 0;
                        h2c_done = 0;
                    end
                end
                default: begin
                    errors++;
                    $display("Unknown operation in stimulus entry %0d", i);
                end
            endcase
        end
        drain();
        $display("Summary: %0d errors, %0d packets checked", errors, pkts_checked);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Limit scales with the stimulus length
    initial begin : watchdog
        wait (rst_n === 1'b1);
        repeat (total_beats * 40 + 2000) @(posedge core_clk);
        $display("Timeout after %0d cycles, traffic or a register access stalled",
                 total_beats * 40 + 2000);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: design/smartnic_app.sv
`timescale 1ns/1ps

module smartnic_app #(
    parameter int DATA_WIDTH = 64
) (
    input  logic                   core_clk,
    input  logic                   rst_n,
    // Ingress stream
    input  logic                   igr_valid,
    output logic                   igr_ready,
    input  logic [DATA_WIDTH-1:0]  igr_data,
    input  logic                   igr_last,
    input  smartnic_pkg::port_t    igr_dest,
    // Card-to-host stream
    output logic                   c2h_valid,
    input  logic                   c2h_ready,
    output logic [DATA_WIDTH-1:0]  c2h_data,
    output logic                   c2h_last,
    output smartnic_pkg::port_t    c2h_dest,
    // Host-to-card stream
    input  logic                   h2c_valid,
    output logic                   h2c_ready,
    input  logic [DATA_WIDTH-1:0]  h2c_data,
    input  logic                   h2c_last,
    input  smartnic_pkg::port_t    h2c_dest,
    // Egress stream
    output logic                   egr_valid,
    input  logic                   egr_ready,
    output logic [DATA_WIDTH-1:0]  egr_data,
    output logic                   egr_last,
    output smartnic_pkg::port_t    egr_dest,
    // Wishbone control
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  smartnic_pkg::wb_addr_t wb_adr,
    input  smartnic_pkg::wb_data_t wb_wdata,
    output logic                   wb_ack,
    output smartnic_pkg::wb_data_t wb_rdata
);
    import smartnic_pkg::*;

    logic                  app_in_valid;
    logic                  app_in_ready;
    logic [DATA_WIDTH-1:0] app_in_data;
    logic                  app_in_last;
    port_t                 app_in_dest;

    logic                  app_out_valid;
    logic                  app_out_ready;
    logic [DATA_WIDTH-1:0] app_out_data;
    logic                  app_out_last;
    port_t                 app_out_dest;

    // ----------------------------------------------------------------------
    // Datapath
    // ----------------------------------------------------------------------
    igr_tdest_demux #(.DATA_WIDTH(DATA_WIDTH)) igr_tdest_demux_inst (
        .core_clk     ( core_clk ),
        .rst_n        ( rst_n ),
        .igr_valid    ( igr_valid ),
        .igr_ready    ( igr_ready ),
        .igr_data     ( igr_data ),
        .igr_last     ( igr_last ),
        .igr_dest     ( igr_dest ),
        .c2h_valid    ( c2h_valid ),
        .c2h_ready    ( c2h_ready ),
        .c2h_data     ( c2h_data ),
        .c2h_last     ( c2h_last ),
        .c2h_dest     ( c2h_dest ),
        .app_in_valid ( app_in_valid ),
        .app_in_ready ( app_in_ready ),
        .app_in_data  ( app_in_data ),
        .app_in_last  ( app_in_last ),
        .app_in_dest  ( app_in_dest )
    );

    app_full_pipe #(.DATA_WIDTH(DATA_WIDTH)) app_full_pipe_inst (
        .core_clk      ( core_clk ),
        .rst_n         ( rst_n ),
        .app_in_valid  ( app_in_valid ),
        .app_in_ready  ( app_in_ready ),
        .app_in_data   ( app_in_data ),
        .app_in_last   ( app_in_last ),
        .app_in_dest   ( app_in_dest ),
        .app_out_valid ( app_out_valid ),
        .app_out_ready ( app_out_ready ),
        .app_out_data  ( app_out_data ),
        .app_out_last  ( app_out_last ),
        .app_out_dest  ( app_out_dest )
    );

    egr_pkt_mux #(.DATA_WIDTH(DATA_WIDTH)) egr_pkt_mux_inst (
        .core_clk      ( core_clk ),
        .rst_n         ( rst_n ),
        .app_out_valid ( app_out_valid ),
        .app_out_ready ( app_out_ready ),
        .app_out_data  ( app_out_data ),
        .app_out_last  ( app_out_last ),
        .app_out_dest  ( app_out_dest ),
        .h2c_valid     ( h2c_valid ),
        .h2c_ready     ( h2c_ready ),
        .h2c_data      ( h2c_data ),
        .h2c_last      ( h2c_last ),
        .h2c_dest      ( h2c_dest ),
        .egr_valid     ( egr_valid ),
        .egr_ready     ( egr_ready ),
        .egr_data      ( egr_data ),
        .egr_last      ( egr_last ),
        .egr_dest      ( egr_dest )
    );

    // ----------------------------------------------------------------------
    // Registers
    // ----------------------------------------------------------------------
    app_reg_blk app_reg_blk_inst (
        .core_clk  ( core_clk ),
        .rst_n     ( rst_n ),
        .wb_cyc    ( wb_cyc ),
        .wb_stb    ( wb_stb ),
        .wb_we     ( wb_we ),
        .wb_adr    ( wb_adr ),
        .wb_wdata  ( wb_wdata ),
        .wb_ack    ( wb_ack ),
        .wb_rdata  ( wb_rdata ),
        .igr_valid ( igr_valid ),
        .igr_ready ( igr_ready ),
        .igr_last  ( igr_last ),
        .c2h_valid ( c2h_valid ),
        .c2h_ready ( c2h_ready ),
        .c2h_last  ( c2h_last ),
        .egr_valid ( egr_valid ),
        .egr_ready ( egr_ready ),
        .egr_last  ( egr_last ),
        .h2c_valid ( h2c_valid ),
        .h2c_ready ( h2c_ready ),
        .h2c_last  ( h2c_last )
    );

endmodule

// File: design/app_reg_blk.sv
`timescale 1ns/1ps

module app_reg_blk (
    input  logic                   core_clk,
    input  logic                   rst_n,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  smartnic_pkg::wb_addr_t wb_adr,
    input  smartnic_pkg::wb_data_t wb_wdata,
    output logic                   wb_ack,
    output smartnic_pkg::wb_data_t wb_rdata,
    input  logic                   igr_valid,
    input  logic                   igr_ready,
    input  logic                   igr_last,
    input  logic                   c2h_valid,
    input  logic                   c2h_ready,
    input  logic                   c2h_last,
    input  logic                   egr_valid,
    input  logic                   egr_ready,
    input  logic                   egr_last,
    input  logic                   h2c_valid,
    input  logic                   h2c_ready,
    input  logic                   h2c_last
);
    import smartnic_pkg::*;

    localparam int NUM_CNT = 4;

    pkt_cnt_t           cnt [NUM_CNT];
    logic [NUM_CNT-1:0] pkt_end;
    logic               req;
    logic               clear;

    // New request, not yet acknowledged
    assign req   = wb_cyc && wb_stb && !wb_ack;
    assign clear = req && wb_we && (wb_adr == REG_CLEAR);

    // Last-beat transfer at each interface
    assign pkt_end[0] = igr_valid && igr_ready && igr_last;
    assign pkt_end[1] = c2h_valid && c2h_ready && c2h_last;
    assign pkt_end[2] = egr_valid && egr_ready && egr_last;
    assign pkt_end[3] = h2c_valid && h2c_ready && h2c_last;

    // ----------------------------------------------------------------------
    // Packet counters, clear takes priority
    // ----------------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        for (int i = 0; i < NUM_CNT; i++) begin
            if (!rst_n || clear) begin
                cnt[i] <= '0;
            end else if (pkt_end[i]) begin
                cnt[i] <= cnt[i] + 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Wishbone access
    // ----------------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    // Read data lines up with the ack
    always_ff @(posedge core_clk) begin
        if (req) begin
            case (wb_adr)
                REG_IGR_PKTS: wb_rdata <= cnt[0];
                REG_C2H_PKTS: wb_rdata <= cnt[1];
                REG_EGR_PKTS: wb_rdata <= cnt[2];
                REG_H2C_PKTS: wb_rdata <= cnt[3];
                default:      wb_rdata <= '0;
            endcase
        end
    end

endmodule

// File: design/egr_pkt_mux.sv
`timescale 1ns/1ps

module egr_pkt_mux #(
    parameter int DATA_WIDTH = 64
) (
    input  logic                  core_clk,
    input  logic                  rst_n,
    input  logic                  app_out_valid,
    output logic                  app_out_ready,
    input  logic [DATA_WIDTH-1:0] app_out_data,
    input  logic                  app_out_last,
    input  smartnic_pkg::port_t   app_out_dest,
    input  logic                  h2c_valid,
    output logic                  h2c_ready,
    input  logic [DATA_WIDTH-1:0] h2c_data,
    input  logic                  h2c_last,
    input  smartnic_pkg::port_t   h2c_dest,
    output logic                  egr_valid,
    input  logic                  egr_ready,
    output logic [DATA_WIDTH-1:0] egr_data,
    output logic                  egr_last,
    output smartnic_pkg::port_t   egr_dest
);
    import smartnic_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        APP,
        H2C
    } egr_mux_state_t;

    egr_mux_state_t state;
    logic           last_h2c;
    logic           pick_h2c;
    logic           pkt_done;

    // Round robin, the source not served last wins a tie
    assign pick_h2c = h2c_valid && (!app_out_valid || !last_h2c);
    assign pkt_done = egr_valid && egr_ready && egr_last;

    // ----------------------------------------------------------------------
    // Grant FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            last_h2c <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    if (app_out_valid || h2c_valid) begin
                        state    <= pick_h2c ? H2C : APP;
                        last_h2c <= pick_h2c;
                    end
                end
                APP, H2C: begin
                    if (pkt_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Output steering
    // ----------------------------------------------------------------------
    always_comb begin
        egr_valid     = 1'b0;
        egr_data      = app_out_data;
        egr_last      = app_out_last;
        egr_dest      = app_out_dest;
        app_out_ready = 1'b0;
        h2c_ready     = 1'b0;
        case (state)
            APP: begin
                egr_valid     = app_out_valid;
                app_out_ready = egr_ready;
            end
            H2C: begin
                egr_valid = h2c_valid;
                egr_data  = h2c_data;
                egr_last  = h2c_last;
                egr_dest  = h2c_dest;
                h2c_ready = egr_ready;
            end
            default: egr_valid = 1'b0;
        endcase
    end

endmodule

// File: design/app_full_pipe.sv
`timescale 1ns/1ps

module app_full_pipe #(
    parameter int DATA_WIDTH = 64
) (
    input  logic                  core_clk,
    input  logic                  rst_n,
    input  logic                  app_in_valid,
    output logic                  app_in_ready,
    input  logic [DATA_WIDTH-1:0] app_in_data,
    input  logic                  app_in_last,
    input  smartnic_pkg::port_t   app_in_dest,
    output logic                  app_out_valid,
    input  logic                  app_out_ready,
    output logic [DATA_WIDTH-1:0] app_out_data,
    output logic                  app_out_last,
    output smartnic_pkg::port_t   app_out_dest
);
    import smartnic_pkg::*;

    // Main register drives the output
    logic                  main_valid;
    logic [DATA_WIDTH-1:0] main_data;
    logic                  main_last;
    port_t                 main_dest;

    // Skid register catches the beat accepted while the output stalls
    logic                  skid_valid;
    logic [DATA_WIDTH-1:0] skid_data;
    logic                  skid_last;
    port_t                 skid_dest;

    logic main_load;

    assign main_load    = app_out_ready || !main_valid;
    assign app_in_ready = !skid_valid;

    assign app_out_valid = main_valid;
    assign app_out_data  = main_data;
    assign app_out_last  = main_last;
    assign app_out_dest  = main_dest;

    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_load) begin
            main_valid <= skid_valid || app_in_valid;
            skid_valid <= 1'b0;
        end else if (app_in_valid && app_in_ready) begin
            skid_valid <= 1'b1;
        end
    end

    // Payload
    always_ff @(posedge core_clk) begin
        if (main_load) begin
            main_data <= skid_valid ? skid_data : app_in_data;
            main_last <= skid_valid ? skid_last : app_in_last;
            main_dest <= skid_valid ? skid_dest : app_in_dest;
        end
        if (!skid_valid) begin
            skid_data <= app_in_data;
            skid_last <= app_in_last;
            skid_dest <= app_in_dest;
        end
    end

endmodule

// File: design/igr_tdest_demux.sv
`timescale 1ns/1ps

module igr_tdest_demux #(
    parameter int DATA_WIDTH = 64
) (
    input  logic                  core_clk,
    input  logic                  rst_n,
    input  logic                  igr_valid,
    output logic                  igr_ready,
    input  logic [DATA_WIDTH-1:0] igr_data,
    input  logic                  igr_last,
    input  smartnic_pkg::port_t   igr_dest,
    output logic                  c2h_valid,
    input  logic                  c2h_ready,
    output logic [DATA_WIDTH-1:0] c2h_data,
    output logic                  c2h_last,
    output smartnic_pkg::port_t   c2h_dest,
    output logic                  app_in_valid,
    input  logic                  app_in_ready,
    output logic [DATA_WIDTH-1:0] app_in_data,
    output logic                  app_in_last,
    output smartnic_pkg::port_t   app_in_dest
);
    import smartnic_pkg::*;

    logic mid_pkt;
    logic sel_held;
    logic sel_first;
    logic sel_c2h;

    // Host codes go to c2h
    always_comb begin
        case (igr_dest)
            PORT_HOST0, PORT_HOST1: sel_first = 1'b1;
            default:                sel_first = 1'b0;
        endcase
    end

    // First beat decides, later beats follow it
    assign sel_c2h = mid_pkt ? sel_held : sel_first;

    assign c2h_valid    = igr_valid && sel_c2h;
    assign c2h_data     = igr_data;
    assign c2h_last     = igr_last;
    assign c2h_dest     = igr_dest;
    assign app_in_valid = igr_valid && !sel_c2h;
    assign app_in_data  = igr_data;
    assign app_in_last  = igr_last;
    assign app_in_dest  = igr_dest;
    assign igr_ready    = sel_c2h ? c2h_ready : app_in_ready;

    always_ff @(posedge core_clk) begin
        if (!rst_n) begin
            mid_pkt  <= 1'b0;
            sel_held <= 1'b0;
        end else if (igr_valid && igr_ready) begin
            mid_pkt  <= !igr_last;
            sel_held <= sel_c2h;
        end
    end

endmodule

// File: design/smartnic_pkg.sv
package smartnic_pkg;

    // ----------------------------------------------------------------------
    // Field types
    // ----------------------------------------------------------------------
    typedef logic [1:0]  port_t;
    typedef logic [31:0] pkt_cnt_t;
    typedef logic [7:0]  wb_addr_t;
    typedef logic [31:0] wb_data_t;

    // ----------------------------------------------------------------------
    // Destination codes
    // ----------------------------------------------------------------------
    // Network ports, handled by the application path
    localparam port_t PORT_P0    = 2'd0;
    localparam port_t PORT_P1    = 2'd1;
    // Host queues, sent straight to c2h
    localparam port_t PORT_HOST0 = 2'd2;
    localparam port_t PORT_HOST1 = 2'd3;

    // ----------------------------------------------------------------------
    // Register map (byte offsets)
    // ----------------------------------------------------------------------
    localparam wb_addr_t REG_IGR_PKTS = 8'h00;
    localparam wb_addr_t REG_C2H_PKTS = 8'h04;
    localparam wb_addr_t REG_EGR_PKTS = 8'h08;
    localparam wb_addr_t REG_H2C_PKTS = 8'h0C;
    localparam wb_addr_t REG_CLEAR    = 8'h10;

endpackage
